//--- filelist.f
+incdir+include
rtl/lsu_pkg.sv
rtl/lsu_addr_gen.sv
rtl/lsu_load_align.sv
rtl/lsu_stage_ctrl.sv
rtl/lsu_pipe.sv
verification/lsu_clock_gen.sv
verification/tb_lsu_pipe.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the load/store pipe testbench with Verilator

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_lsu_pipe \
  -o tb_lsu_pipe > build.log 2>&1 \
  && ./obj_dir/tb_lsu_pipe > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/tb_lsu_pipe.sv
// Load/store pipe testbench
// L1D and forwarding models, reference load, stimulus, output checker, watchdog

`include "lsu_defs.svh"

module tb_lsu_pipe;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_OPS    = 43;
  localparam int CYC_PER_OP = 6;     // Issue plus drain when ops run one at a time
  localparam int CLK_NS     = 100;
  localparam int EX2_LAT    = 3;     // Drive edge to EX2 sample
  localparam int DONE_LAT   = 4;     // Drive edge to EX3 sample, counted in cycle_cnt

  typedef struct packed {
    lsu_pkg::tag_t     tag;
    logic              replay;
    lsu_pkg::hazard_e  hazard;
    lsu_pkg::except_e  except_type;
    lsu_pkg::xlen_t    tval;
    logic              has_wb;
    lsu_pkg::xlen_t    data;
    lsu_pkg::byte_en_t need;
    int unsigned       cyc;
  } exp_rec_t;

  typedef struct packed {
    lsu_pkg::tag_t      tag;
    lsu_pkg::xlen_t     paddr;
    lsu_pkg::mem_size_e size;
    logic               except_valid;
  } stq_rec_t;

  logic                 i_clk;
  logic                 i_reset_n;
  logic                 i_flush;
  lsu_pkg::lsu_issue_t  i_issue;
  lsu_pkg::l1d_resp_t   i_l1d_resp = '0;
  lsu_pkg::fwd_resp_t   i_fwd_resp;
  lsu_pkg::l1d_req_t    o_l1d_req;
  lsu_pkg::fwd_req_t    o_fwd_req;
  lsu_pkg::stq_update_t o_stq_update;
  lsu_pkg::replay_t     o_replay;
  lsu_pkg::done_t       o_done;
  lsu_pkg::wb_t         o_wb;

  logic [7:0]     mem [0:4095];
  logic           fwd_valid [4];
  lsu_pkg::xlen_t fwd_addr [4];
  lsu_pkg::byte_en_t fwd_mask [4];
  lsu_pkg::xlen_t fwd_data [4];
  lsu_pkg::line_t mem_line;
  logic           force_miss = 1'b0;
  logic           force_conflict = 1'b0;

  exp_rec_t      exp_q [$];
  stq_rec_t      stq_q [$];
  int            seed = 81447;
  int unsigned   cycle_cnt = 0;
  int            l1d_req_cnt = 0;
  int            err_cnt = 0;
  int            err_at_start;
  int            tests_run = 0;
  int            tests_failed = 0;
  string         cur_test = "reset";
  lsu_pkg::tag_t next_tag = '0;

  lsu_clock_gen clk_gen_i (
    .o_clk     (i_clk),
    .o_reset_n (i_reset_n)
  );

  lsu_pipe dut_i (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_flush      (i_flush),
    .i_issue      (i_issue),
    .o_l1d_req    (o_l1d_req),
    .i_l1d_resp   (i_l1d_resp),
    .o_fwd_req    (o_fwd_req),
    .i_fwd_resp   (i_fwd_resp),
    .o_stq_update (o_stq_update),
    .o_replay     (o_replay),
    .o_done       (o_done),
    .o_wb         (o_wb)
  );

  always @(posedge i_clk) cycle_cnt <= cycle_cnt + 1;

  // ------------------------------
  // L1D and forwarding models
  // ------------------------------
  always_comb begin
    for (int b = 0; b < `LSU_LINE_B; b++) begin
      mem_line[b*8 +: 8] = mem[o_l1d_req.paddr[11:0] + 12'(b)];
    end
  end

  always @(posedge i_clk) begin
    i_l1d_resp.line     <= mem_line;
    i_l1d_resp.hit      <= o_l1d_req.valid & ~force_miss & ~force_conflict;
    i_l1d_resp.miss     <= o_l1d_req.valid & force_miss;
    i_l1d_resp.conflict <= o_l1d_req.valid & force_conflict;
  end

  always_comb begin
    i_fwd_resp = '0;
    for (int e = 0; e < 4; e++) begin
      if (o_fwd_req.valid && fwd_valid[e] && fwd_addr[e][63:3] == o_fwd_req.paddr[63:3]) begin
        i_fwd_resp.byte_en = fwd_mask[e];
        i_fwd_resp.data    = fwd_data[e];
      end
    end
  end

  function automatic lsu_pkg::byte_en_t fwd_mask_at(input lsu_pkg::xlen_t addr);
    lsu_pkg::byte_en_t m;
    m = '0;
    for (int e = 0; e < 4; e++) begin
      if (fwd_valid[e] && fwd_addr[e][63:3] == addr[63:3]) m = fwd_mask[e];
    end
    return m;
  endfunction

  function automatic lsu_pkg::xlen_t fwd_data_at(input lsu_pkg::xlen_t addr);
    lsu_pkg::xlen_t d;
    d = '0;
    for (int e = 0; e < 4; e++) begin
      if (fwd_valid[e] && fwd_addr[e][63:3] == addr[63:3]) d = fwd_data[e];
    end
    return d;
  endfunction

  // ------------------------------
  // Reference
  // ------------------------------
  function automatic lsu_pkg::byte_en_t needed_bytes(input lsu_pkg::xlen_t addr,
                                                     input lsu_pkg::mem_size_e size);
    logic [15:0] m;
    int          nb;
    nb = 1 << size;
    m  = 16'((1 << nb) - 1);
    m  = m << addr[2:0];
    return m[7:0];
  endfunction

  function automatic lsu_pkg::xlen_t ref_load(input lsu_pkg::xlen_t addr,
                                              input lsu_pkg::mem_size_e size,
                                              input logic sign);
    lsu_pkg::xlen_t    dw;
    lsu_pkg::xlen_t    sh;
    lsu_pkg::byte_en_t fm;
    lsu_pkg::xlen_t    fd;
    fm = fwd_mask_at(addr);
    fd = fwd_data_at(addr);
    for (int b = 0; b < 8; b++) begin
      dw[b*8 +: 8] = fm[b] ? fd[b*8 +: 8] : mem[{addr[11:3], 3'(b)}];
    end
    sh = dw >> {addr[2:0], 3'b000};
    case (size)
      lsu_pkg::SIZE_B:  return sign ? {{56{sh[7]}}, sh[7:0]}   : {56'd0, sh[7:0]};
      lsu_pkg::SIZE_H:  return sign ? {{48{sh[15]}}, sh[15:0]} : {48'd0, sh[15:0]};
      lsu_pkg::SIZE_W:  return sign ? {{32{sh[31]}}, sh[31:0]} : {32'd0, sh[31:0]};
      default:          return sh;
    endcase
  endfunction

  function automatic lsu_pkg::xlen_t rand_xlen();
    return {32'($random(seed)), 32'($random(seed))};
  endfunction

  task automatic check_value(input string what, input lsu_pkg::xlen_t exp_v,
                             input lsu_pkg::xlen_t act_v);
    if (exp_v !== act_v) begin
      $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
      err_cnt++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("%s: %s", cur_test, msg);
    err_cnt++;
  endtask

  // ------------------------------
  // Output checker
  // ------------------------------
  always @(negedge i_clk) begin : compare_outputs
    exp_rec_t rec;
    stq_rec_t srec;
    if (i_reset_n) begin
      // Tracked op now in EX2
      for (int i = 0; i < exp_q.size(); i++) begin
        if (exp_q[i].cyc + EX2_LAT == cycle_cnt) begin
          check_value("fwd valid", 64'(exp_q[i].has_wb | exp_q[i].replay),
                      64'(o_fwd_req.valid));
          if (exp_q[i].has_wb | exp_q[i].replay) begin
            check_value("fwd paddr", exp_q[i].tval, o_fwd_req.paddr);
            check_value("fwd bytes", 64'(exp_q[i].need), 64'(o_fwd_req.byte_en));
          end
        end
      end
      if (o_l1d_req.valid) l1d_req_cnt++;
      if (o_stq_update.valid) begin
        if (stq_q.size() == 0) begin
          report_error("store queue update with no store pending");
        end else begin
          srec = stq_q.pop_front();
          check_value("stq tag", 64'(srec.tag), 64'(o_stq_update.tag));
          check_value("stq paddr", srec.paddr, o_stq_update.paddr);
          check_value("stq size", 64'(srec.size), 64'(o_stq_update.size));
          check_value("stq except", 64'(srec.except_valid), 64'(o_stq_update.except_valid));
        end
      end
      if (o_wb.valid && !o_done.valid) report_error("writeback without done");
      if (o_done.valid) begin
        if (exp_q.size() == 0 || exp_q[0].replay) begin
          report_error($sformatf("unexpected done for tag %0d", o_done.tag));
        end else begin
          rec = exp_q.pop_front();
          check_value("done tag", 64'(rec.tag), 64'(o_done.tag));
          check_value("except", 64'(rec.except_type), 64'(o_done.except_type));
          if (rec.except_type != lsu_pkg::EXC_NONE) check_value("tval", rec.tval, o_done.tval);
          check_value("latency", 64'(DONE_LAT), 64'(cycle_cnt - rec.cyc));
          check_value("wb valid", 64'(rec.has_wb), 64'(o_wb.valid));
          if (rec.has_wb) begin
            check_value("wb tag", 64'(rec.tag), 64'(o_wb.tag));
            check_value("wb data", rec.data, o_wb.data);
          end
        end
      end
      if (o_replay.valid) begin
        if (exp_q.size() == 0 || !exp_q[0].replay) begin
          report_error($sformatf("unexpected replay for tag %0d", o_replay.tag));
        end else begin
          rec = exp_q.pop_front();
          check_value("replay tag", 64'(rec.tag), 64'(o_replay.tag));
          check_value("hazard", 64'(rec.hazard), 64'(o_replay.hazard));
          check_value("replay latency", 64'(EX2_LAT), 64'(cycle_cnt - rec.cyc));
        end
      end
    end
  end

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic issue_op(input lsu_pkg::mem_op_e op, input lsu_pkg::mem_size_e size,
                          input logic sign, input lsu_pkg::xlen_t base,
                          input lsu_pkg::offset_t offset, input logic track,
                          input logic flush);
    exp_rec_t          rec;
    stq_rec_t          srec;
    lsu_pkg::xlen_t    addr;
    lsu_pkg::byte_en_t need;
    logic              misalign;
    @(posedge i_clk);
    addr     = base + {{52{offset[11]}}, offset};
    misalign = (addr[2:0] & 3'((1 << size) - 1)) != 3'd0;
    rec      = '0;
    rec.tag  = next_tag;
    rec.tval = addr;
    rec.cyc  = cycle_cnt;
    if (misalign) begin
      rec.except_type = (op == lsu_pkg::OP_LOAD) ? lsu_pkg::EXC_LOAD_MISALIGN :
                                                   lsu_pkg::EXC_STORE_MISALIGN;
    end else if (op == lsu_pkg::OP_LOAD) begin
      need     = needed_bytes(addr, size);
      rec.need = need;
      if ((need & ~fwd_mask_at(addr)) != '0 && (force_conflict || force_miss)) begin
        rec.replay = 1'b1;
        rec.hazard = force_conflict ? lsu_pkg::HAZ_L1D_CONFLICT : lsu_pkg::HAZ_L1D_MISS;
      end else begin
        rec.has_wb = 1'b1;
        rec.data   = ref_load(addr, size, sign);
      end
    end
    i_issue <= '{valid: 1'b1, op: op, size: size, sign: sign, tag: next_tag,
                 base: base, offset: offset};
    i_flush <= flush;
    if (track) begin
      exp_q.push_back(rec);
      if (op == lsu_pkg::OP_STORE) begin
        srec = '{tag: next_tag, paddr: addr, size: size, except_valid: misalign};
        stq_q.push_back(srec);
      end
    end
    next_tag++;
  endtask

  task automatic wait_idle();
    @(posedge i_clk);
    i_issue <= '0;
    i_flush <= 1'b0;
    while (exp_q.size() != 0 || stq_q.size() != 0) @(posedge i_clk);
    repeat (2) @(posedge i_clk);
  endtask

  task automatic set_l1d_mode(input logic miss, input logic conflict);
    @(posedge i_clk);
    force_miss     <= miss;
    force_conflict <= conflict;
  endtask

  task automatic set_fwd(input int idx, input lsu_pkg::xlen_t addr,
                         input lsu_pkg::byte_en_t mask, input lsu_pkg::xlen_t data);
    fwd_valid[idx] = 1'b1;
    fwd_addr[idx]  = addr;
    fwd_mask[idx]  = mask;
    fwd_data[idx]  = data;
  endtask

  task automatic start_test(input string name);
    cur_test     = name;
    err_at_start = err_cnt;
    for (int e = 0; e < 4; e++) fwd_valid[e] = 1'b0;
  endtask

  task automatic end_test();
    wait_idle();
    tests_run++;
    if (err_cnt == err_at_start) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d errors", cur_test, err_cnt - err_at_start);
      tests_failed++;
    end
  endtask

  function automatic lsu_pkg::xlen_t aligned_addr();
    return rand_xlen() & ~64'h7;
  endfunction

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin
    #((NUM_OPS * CYC_PER_OP + 20) * CLK_NS);
    $display("Watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin : main
    lsu_pkg::offset_t off;
    lsu_pkg::xlen_t   a;
    int               req_base;
    for (int i = 0; i < 4096; i++) begin
      mem[i] = 8'(i) ^ {4'(i >> 8), 4'(i >> 8)} ^ 8'ha5;   // Whole-index pattern
    end
    for (int e = 0; e < 4; e++) fwd_valid[e] = 1'b0;
    i_issue = '0;
    i_flush = 1'b0;
    @(posedge i_reset_n);

    start_test("aligned_loads");
    req_base = l1d_req_cnt;
    for (int n = 0; n < 16; n++) begin
      off      = lsu_pkg::offset_t'($random(seed));
      off[2:0] = 3'b000;
      issue_op(lsu_pkg::OP_LOAD, lsu_pkg::mem_size_e'(2'($random(seed))),
               1'($random(seed)), aligned_addr(), off, 1'b1, 1'b0);
    end
    wait_idle();
    check_value("l1d requests", 64'd16, 64'(l1d_req_cnt - req_base));
    end_test();

    start_test("stores");
    for (int n = 0; n < 6; n++) begin
      off      = lsu_pkg::offset_t'($random(seed));
      off[2:0] = 3'b000;
      issue_op(lsu_pkg::OP_STORE, lsu_pkg::mem_size_e'(2'(n)), 1'b0, aligned_addr(), off,
               1'b1, 1'b0);
    end
    end_test();

    start_test("misaligned");
    req_base = l1d_req_cnt;
    for (int n = 0; n < 6; n++) begin
      issue_op((n < 3) ? lsu_pkg::OP_LOAD : lsu_pkg::OP_STORE,
               lsu_pkg::mem_size_e'(2'(n % 3 + 1)), 1'b1, aligned_addr(),
               12'sd1 + 12'(2 * n), 1'b1, 1'b0);
    end
    wait_idle();
    check_value("l1d requests", 64'd0, 64'(l1d_req_cnt - req_base));
    end_test();

    start_test("forwarding");
    a = aligned_addr();
    set_fwd(0, a, 8'hff, rand_xlen());
    set_l1d_mode(1'b1, 1'b0);
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_DW, 1'b0, a, 12'sd0, 1'b1, 1'b0);
    wait_idle();
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_W, 1'b1, a, 12'sd4, 1'b1, 1'b0);
    wait_idle();
    set_l1d_mode(1'b0, 1'b0);
    a = aligned_addr();
    set_fwd(1, a, 8'h0f, rand_xlen());
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_DW, 1'b0, a, 12'sd0, 1'b1, 1'b0);
    wait_idle();
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_H, 1'b1, a, 12'sd2, 1'b1, 1'b0);
    end_test();

    start_test("replay");
    a = aligned_addr();
    set_l1d_mode(1'b1, 1'b0);
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_W, 1'b0, a, 12'sd0, 1'b1, 1'b0);
    wait_idle();
    set_l1d_mode(1'b1, 1'b1);
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_B, 1'b1, a, 12'sd3, 1'b1, 1'b0);
    wait_idle();
    set_l1d_mode(1'b0, 1'b1);
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_DW, 1'b0, a, 12'sd8, 1'b1, 1'b0);
    wait_idle();
    set_fwd(0, a, 8'h01, rand_xlen());   // Partial cover only
    set_l1d_mode(1'b1, 1'b0);
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_DW, 1'b0, a, 12'sd0, 1'b1, 1'b0);
    wait_idle();
    issue_op(lsu_pkg::OP_STORE, lsu_pkg::SIZE_DW, 1'b0, a, 12'sd16, 1'b1, 1'b0);
    wait_idle();
    set_l1d_mode(1'b0, 1'b0);
    end_test();

    start_test("flush");
    set_l1d_mode(1'b1, 1'b0);   // Killed EX2 load would replay
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_DW, 1'b0, aligned_addr(), 12'sd0, 1'b0, 1'b0);
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_W, 1'b1, aligned_addr(), 12'sd0, 1'b0, 1'b0);
    issue_op(lsu_pkg::OP_LOAD, lsu_pkg::SIZE_H, 1'b0, aligned_addr(), 12'sd0, 1'b0, 1'b1);
    wait_idle();
    set_l1d_mode(1'b0, 1'b0);
    for (int n = 0; n < 3; n++) begin
      issue_op(lsu_pkg::OP_LOAD, lsu_pkg::mem_size_e'(2'(n)), 1'b1, aligned_addr(), 12'sd0,
               1'b1, 1'b0);
    end
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- verification/lsu_clock_gen.sv
// Testbench clock and reset source
// 100 ns clock, active-low reset held for 8 cycles

module lsu_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD_NS = 50;
  localparam int RESET_CYCLES   = 8;

  initial o_clk = 1'b0;

  always #HALF_PERIOD_NS o_clk = ~o_clk;

  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

//--- rtl/lsu_pipe.sv
// Load/store execution pipe top level
// Address generation, load alignment and stage control

module lsu_pipe (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  logic                 i_flush,
  input  lsu_pkg::lsu_issue_t  i_issue,
  output lsu_pkg::l1d_req_t    o_l1d_req,
  input  lsu_pkg::l1d_resp_t   i_l1d_resp,
  output lsu_pkg::fwd_req_t    o_fwd_req,
  input  lsu_pkg::fwd_resp_t   i_fwd_resp,
  output lsu_pkg::stq_update_t o_stq_update,
  output lsu_pkg::replay_t     o_replay,
  output lsu_pkg::done_t       o_done,
  output lsu_pkg::wb_t         o_wb
);

  // EX1
  lsu_pkg::lsu_issue_t w_ex1_issue;
  lsu_pkg::xlen_t      w_ex1_vaddr;
  lsu_pkg::except_e    w_ex1_except;

  // EX2
  lsu_pkg::mem_size_e  w_ex2_size;
  logic                w_ex2_sign;
  lsu_pkg::xlen_t      w_ex2_vaddr;
  lsu_pkg::byte_en_t   w_ex2_byte_en;
  lsu_pkg::xlen_t      w_ex2_data;
  logic                w_ex2_fwd_complete;

  lsu_addr_gen u_addr_gen (
    .i_ex1_issue  (w_ex1_issue),
    .o_vaddr      (w_ex1_vaddr),
    .o_except     (w_ex1_except),
    .o_l1d_req    (o_l1d_req),
    .o_stq_update (o_stq_update)
  );

  lsu_load_align u_load_align (
    .i_size         (w_ex2_size),
    .i_sign         (w_ex2_sign),
    .i_vaddr        (w_ex2_vaddr),
    .i_line         (i_l1d_resp.line),
    .i_fwd_resp     (i_fwd_resp),
    .o_byte_en      (w_ex2_byte_en),
    .o_data         (w_ex2_data),
    .o_fwd_complete (w_ex2_fwd_complete)
  );

  lsu_stage_ctrl u_stage_ctrl (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_flush            (i_flush),
    .i_issue            (i_issue),
    .i_ex1_vaddr        (w_ex1_vaddr),
    .i_ex1_except       (w_ex1_except),
    .i_l1d_resp         (i_l1d_resp),
    .i_ex2_data         (w_ex2_data),
    .i_ex2_fwd_complete (w_ex2_fwd_complete),
    .i_ex2_byte_en      (w_ex2_byte_en),
    .o_ex1_issue        (w_ex1_issue),
    .o_ex2_size         (w_ex2_size),
    .o_ex2_sign         (w_ex2_sign),
    .o_ex2_vaddr        (w_ex2_vaddr),
    .o_fwd_req          (o_fwd_req),
    .o_replay           (o_replay),
    .o_done             (o_done),
    .o_wb               (o_wb)
  );

endmodule

//--- rtl/lsu_stage_ctrl.sv
// EX1/EX2/EX3 stage registers and control
// Flush kill, EX2 forward request and replay decision, EX3 done and writeback

module lsu_stage_ctrl (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_flush,
  input  lsu_pkg::lsu_issue_t i_issue,
  input  lsu_pkg::xlen_t      i_ex1_vaddr,
  input  lsu_pkg::except_e    i_ex1_except,
  input  lsu_pkg::l1d_resp_t  i_l1d_resp,
  input  lsu_pkg::xlen_t      i_ex2_data,
  input  logic                i_ex2_fwd_complete,
  input  lsu_pkg::byte_en_t   i_ex2_byte_en,
  output lsu_pkg::lsu_issue_t o_ex1_issue,
  output lsu_pkg::mem_size_e  o_ex2_size,
  output logic                o_ex2_sign,
  output lsu_pkg::xlen_t      o_ex2_vaddr,
  output lsu_pkg::fwd_req_t   o_fwd_req,
  output lsu_pkg::replay_t    o_replay,
  output lsu_pkg::done_t      o_done,
  output lsu_pkg::wb_t        o_wb
);

  // Stage valids
  logic r_ex1_valid;
  logic r_ex2_valid;
  logic r_ex3_valid;

  lsu_pkg::lsu_issue_t r_ex1_issue;

  lsu_pkg::mem_op_e    r_ex2_op;
  lsu_pkg::mem_size_e  r_ex2_size;
  logic                r_ex2_sign;
  lsu_pkg::tag_t       r_ex2_tag;
  lsu_pkg::xlen_t      r_ex2_vaddr;
  lsu_pkg::except_e    r_ex2_except;

  lsu_pkg::tag_t       r_ex3_tag;
  logic                r_ex3_has_wb;
  lsu_pkg::xlen_t      r_ex3_data;
  lsu_pkg::except_e    r_ex3_except;
  lsu_pkg::xlen_t      r_ex3_tval;

  logic                w_ex2_load;
  lsu_pkg::hazard_e    w_ex2_hazard;
  logic                w_ex3_valid_next;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex1_valid <= i_issue.valid & ~i_flush;
      r_ex2_valid <= r_ex1_valid & ~i_flush;
      r_ex3_valid <= w_ex3_valid_next;
    end
  end

  // ------------------------------
  // EX1
  // ------------------------------
  always_ff @(posedge i_clk) begin
    r_ex1_issue <= i_issue;
  end

  always_comb begin
    o_ex1_issue       = r_ex1_issue;
    o_ex1_issue.valid = r_ex1_valid;
  end

  // ------------------------------
  // EX2
  // ------------------------------
  always_ff @(posedge i_clk) begin
    r_ex2_op     <= r_ex1_issue.op;
    r_ex2_size   <= r_ex1_issue.size;
    r_ex2_sign   <= r_ex1_issue.sign;
    r_ex2_tag    <= r_ex1_issue.tag;
    r_ex2_vaddr  <= i_ex1_vaddr;
    r_ex2_except <= i_ex1_except;
  end

  assign o_ex2_size  = r_ex2_size;
  assign o_ex2_sign  = r_ex2_sign;
  assign o_ex2_vaddr = r_ex2_vaddr;

  // Only loads that reached the L1D need data
  assign w_ex2_load = r_ex2_valid & (r_ex2_op == lsu_pkg::OP_LOAD) &
                      (r_ex2_except == lsu_pkg::EXC_NONE);

  always_comb begin
    o_fwd_req.valid   = w_ex2_load;
    o_fwd_req.paddr   = r_ex2_vaddr;
    o_fwd_req.byte_en = i_ex2_byte_en;
  end

  // Full forwarding hides any L1D miss or conflict
  always_comb begin
    w_ex2_hazard = lsu_pkg::HAZ_NONE;
    if (w_ex2_load & ~i_ex2_fwd_complete) begin
      if (i_l1d_resp.conflict) begin
        w_ex2_hazard = lsu_pkg::HAZ_L1D_CONFLICT;
      end else if (i_l1d_resp.miss) begin
        w_ex2_hazard = lsu_pkg::HAZ_L1D_MISS;
      end
    end
  end

  always_comb begin
    o_replay.valid  = r_ex2_valid & (w_ex2_hazard != lsu_pkg::HAZ_NONE) & ~i_flush;
    o_replay.tag    = r_ex2_tag;
    o_replay.hazard = w_ex2_hazard;
  end

  assign w_ex3_valid_next = r_ex2_valid & (w_ex2_hazard == lsu_pkg::HAZ_NONE) & ~i_flush;

  // ------------------------------
  // EX3
  // ------------------------------
  always_ff @(posedge i_clk) begin
    r_ex3_tag    <= r_ex2_tag;
    r_ex3_has_wb <= w_ex2_load;
    r_ex3_data   <= i_ex2_data;
    r_ex3_except <= r_ex2_except;
    r_ex3_tval   <= r_ex2_vaddr;
  end

  always_comb begin
    o_done.valid       = r_ex3_valid;
    o_done.tag         = r_ex3_tag;
    o_done.except_type = r_ex3_except;
    o_done.tval        = r_ex3_tval;

    o_wb.valid = r_ex3_valid & r_ex3_has_wb;   // Stores and faulting loads write nothing
    o_wb.tag   = r_ex3_tag;
    o_wb.data  = r_ex3_data;
  end

endmodule

//--- rtl/lsu_load_align.sv
// EX2 load data path
// Byte mask, doubleword select, store forward merge, coverage check, extension

`include "lsu_defs.svh"

module lsu_load_align (
  input  lsu_pkg::mem_size_e i_size,
  input  logic               i_sign,
  input  lsu_pkg::xlen_t     i_vaddr,
  input  lsu_pkg::line_t     i_line,
  input  lsu_pkg::fwd_resp_t i_fwd_resp,
  output lsu_pkg::byte_en_t  o_byte_en,
  output lsu_pkg::xlen_t     o_data,
  output logic               o_fwd_complete
);

  localparam int DW_OFS_W   = $clog2(`LSU_XLEN_B);
  localparam int LINE_OFS_W = $clog2(`LSU_LINE_B);

  logic [DW_OFS_W-1:0]                w_dw_ofs;
  logic [LINE_OFS_W-DW_OFS_W-1:0]     w_dw_idx;
  lsu_pkg::byte_en_t                  w_size_mask;
  lsu_pkg::byte_en_t                  w_byte_en;
  lsu_pkg::xlen_t                     w_l1d_dw;
  lsu_pkg::xlen_t                     w_merged;
  lsu_pkg::xlen_t                     w_shifted;

  assign w_dw_ofs = i_vaddr[DW_OFS_W-1:0];
  assign w_dw_idx = i_vaddr[LINE_OFS_W-1:DW_OFS_W];

  // ------------------------------
  // Needed bytes
  // ------------------------------
  always_comb begin
    case (i_size)
      lsu_pkg::SIZE_B: w_size_mask = 8'h01;
      lsu_pkg::SIZE_H: w_size_mask = 8'h03;
      lsu_pkg::SIZE_W: w_size_mask = 8'h0f;
      default:         w_size_mask = 8'hff;
    endcase
  end

  assign w_byte_en = lsu_pkg::byte_en_t'(w_size_mask << w_dw_ofs);
  assign o_byte_en = w_byte_en;

  // ------------------------------
  // Merge
  // ------------------------------
  assign w_l1d_dw = i_line[w_dw_idx * `LSU_XLEN_W +: `LSU_XLEN_W];

  // Store queue bytes win over the cache
  always_comb begin
    for (int b = 0; b < `LSU_XLEN_B; b++) begin
      w_merged[b*8 +: 8] = i_fwd_resp.byte_en[b] ? i_fwd_resp.data[b*8 +: 8] :
                                                   w_l1d_dw[b*8 +: 8];
    end
  end

  assign o_fwd_complete = &(~w_byte_en | i_fwd_resp.byte_en);

  // ------------------------------
  // Align and extend
  // ------------------------------
  assign w_shifted = w_merged >> {w_dw_ofs, 3'b000};

  always_comb begin
    case (i_size)
      lsu_pkg::SIZE_B: begin
        o_data = {{(`LSU_XLEN_W-8){i_sign & w_shifted[7]}}, w_shifted[7:0]};
      end
      lsu_pkg::SIZE_H: begin
        o_data = {{(`LSU_XLEN_W-16){i_sign & w_shifted[15]}}, w_shifted[15:0]};
      end
      lsu_pkg::SIZE_W: begin
        o_data = {{(`LSU_XLEN_W-32){i_sign & w_shifted[31]}}, w_shifted[31:0]};
      end
      default: begin
        o_data = w_shifted;   // Full doubleword, nothing to extend
      end
    endcase
  end

endmodule

//--- rtl/lsu_addr_gen.sv
// EX1 address generation
// Base plus offset, misalignment check, L1D read request, store-queue report

`include "lsu_defs.svh"

module lsu_addr_gen (
  input  lsu_pkg::lsu_issue_t  i_ex1_issue,
  output lsu_pkg::xlen_t       o_vaddr,
  output lsu_pkg::except_e     o_except,
  output lsu_pkg::l1d_req_t    o_l1d_req,
  output lsu_pkg::stq_update_t o_stq_update
);

  localparam int LINE_OFS_W = $clog2(`LSU_LINE_B);

  lsu_pkg::xlen_t   w_offset_ext;
  lsu_pkg::xlen_t   w_vaddr;
  lsu_pkg::except_e w_except;
  logic             w_misalign;
  logic             w_is_load;

  assign w_is_load = (i_ex1_issue.op == lsu_pkg::OP_LOAD);

  // ------------------------------
  // Address
  // ------------------------------
  assign w_offset_ext = {{(`LSU_XLEN_W - `LSU_OFFSET_W){i_ex1_issue.offset[`LSU_OFFSET_W-1]}},
                         i_ex1_issue.offset};
  assign w_vaddr      = i_ex1_issue.base + w_offset_ext;   // PA == VA, no TLB

  // Natural alignment per access size
  always_comb begin
    case (i_ex1_issue.size)
      lsu_pkg::SIZE_H:  w_misalign = w_vaddr[0];
      lsu_pkg::SIZE_W:  w_misalign = |w_vaddr[1:0];
      lsu_pkg::SIZE_DW: w_misalign = |w_vaddr[2:0];
      default:          w_misalign = 1'b0;
    endcase
  end

  assign w_except = !w_misalign ? lsu_pkg::EXC_NONE          :
                    w_is_load   ? lsu_pkg::EXC_LOAD_MISALIGN :
                                  lsu_pkg::EXC_STORE_MISALIGN;

  assign o_vaddr  = w_vaddr;
  assign o_except = w_except;

  // ------------------------------
  // L1D read request
  // ------------------------------
  always_comb begin
    o_l1d_req.valid = i_ex1_issue.valid & w_is_load & (w_except == lsu_pkg::EXC_NONE);
    o_l1d_req.paddr = {w_vaddr[`LSU_XLEN_W-1:LINE_OFS_W], {LINE_OFS_W{1'b0}}};
  end

  // ------------------------------
  // Store queue address report
  // ------------------------------
  always_comb begin
    o_stq_update.valid        = i_ex1_issue.valid & ~w_is_load;
    o_stq_update.tag          = i_ex1_issue.tag;
    o_stq_update.paddr        = w_vaddr;
    o_stq_update.size         = i_ex1_issue.size;
    o_stq_update.except_valid = (w_except != lsu_pkg::EXC_NONE);
  end

endmodule

//--- rtl/lsu_pkg.sv
// Load/store pipe types
// Vector typedefs, op/size/exception/hazard enums and the bus structs

`include "lsu_defs.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN_W-1:0]          xlen_t;
  typedef logic [`LSU_LINE_W-1:0]          line_t;
  typedef logic signed [`LSU_OFFSET_W-1:0] offset_t;
  typedef logic [`LSU_TAG_W-1:0]           tag_t;
  typedef logic [`LSU_XLEN_B-1:0]          byte_en_t;   // One bit per doubleword byte

  typedef enum logic {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } mem_size_e;

  typedef enum logic [1:0] {
    EXC_NONE           = 2'd0,
    EXC_LOAD_MISALIGN  = 2'd1,
    EXC_STORE_MISALIGN = 2'd2
  } except_e;

  typedef enum logic [1:0] {
    HAZ_NONE         = 2'd0,
    HAZ_L1D_MISS     = 2'd1,
    HAZ_L1D_CONFLICT = 2'd2
  } hazard_e;

  // ------------------------------
  // Bus payloads
  // ------------------------------
  typedef struct packed {
    logic      valid;
    mem_op_e   op;
    mem_size_e size;
    logic      sign;     // Sign-extend loaded data
    tag_t      tag;
    xlen_t     base;
    offset_t   offset;
  } lsu_issue_t;

  typedef struct packed {
    logic  valid;
    xlen_t paddr;        // Line aligned
  } l1d_req_t;

  typedef struct packed {
    logic  hit;
    logic  miss;
    logic  conflict;
    line_t line;
  } l1d_resp_t;

  typedef struct packed {
    logic     valid;
    xlen_t    paddr;
    byte_en_t byte_en;
  } fwd_req_t;

  typedef struct packed {
    byte_en_t byte_en;
    xlen_t    data;      // Doubleword lanes
  } fwd_resp_t;

  typedef struct packed {
    logic      valid;
    tag_t      tag;
    xlen_t     paddr;
    mem_size_e size;
    logic      except_valid;
  } stq_update_t;

  typedef struct packed {
    logic    valid;
    tag_t    tag;
    hazard_e hazard;
  } replay_t;

  typedef struct packed {
    logic    valid;
    tag_t    tag;
    except_e except_type;
    xlen_t   tval;
  } done_t;

  typedef struct packed {
    logic  valid;
    tag_t  tag;
    xlen_t data;
  } wb_t;

endpackage

//--- include/lsu_defs.svh
// Width constants for the load/store pipe
// Data, line, immediate and tag widths

`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ------------------------------
// Data path
// ------------------------------
`define LSU_XLEN_W   64
`define LSU_XLEN_B   (`LSU_XLEN_W / 8)   // Bytes per doubleword

// ------------------------------
// L1D line
// ------------------------------
`define LSU_LINE_B   16
`define LSU_LINE_W   (`LSU_LINE_B * 8)

// ------------------------------
// Operation fields
// ------------------------------
`define LSU_OFFSET_W 12   // Immediate
`define LSU_TAG_W    6

`endif
